// File: bit_table.f
source/bit_table_pkg.sv
source/bit_wr_if.sv
source/bit_cmd_decode.sv
source/mem_1rw_sync_mask_write_bit.sv
source/bit_read_result.sv
source/bit_table_top.sv
dv/tb_clock_gen.sv
dv/bit_table_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bit-state table testbench with Verilator and run it.
# The run passes only if the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f bit_table.f --top-module bit_table_tb -o bit_table_sim > build.log 2>&1 \
  && ./obj_dir/bit_table_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2> /dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log

grep -qx "TEST OK" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// File: dv/bit_table_tb.sv
// Bit-state table testbench.
// Table-driven commands against a reference model of the masked RAM.
`timescale 1ns/1ps
`default_nettype none

module bit_table_tb;

  localparam int WIDTH  = bit_table_pkg::WIDTH;
  localparam int ELS    = bit_table_pkg::ELS;
  localparam int ADDR_W = bit_table_pkg::ADDR_W;
  localparam int CNT_W  = bit_table_pkg::CNT_W;
  localparam int IDX_W  = bit_table_pkg::IDX_W;
  localparam logic [31:0] SEED = 32'h20df_78f8;

  typedef logic [WIDTH-1:0]  data_t;
  typedef logic [CNT_W-1:0]  ones_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [IDX_W-1:0]  idx_t;

  // One command of the stimulus table.
  typedef struct {
    string                       name;
    bit_table_pkg::bit_op_e      op;
    addr_t                       addr;
    bit_table_pkg::bit_payload_u payload;
    bit                          check;  // Compare the read response.
    int                          gap;    // Idle cycles after it.
  } entry_t;

  // Expected response of one read.
  typedef struct {
    string name;
    data_t data;
    ones_t ones;
    int    due;   // Cycle count when rsp_v_o is due.
    bit    check;
  } resp_t;

  logic                    clk;
  logic                    rst_n;
  logic                    cmd_v;
  bit_table_pkg::bit_cmd_t cmd;
  logic                    rsp_v;
  data_t                   rsp_data;
  ones_t                   rsp_ones;

  entry_t tbl[$];
  resp_t  exp_q[$];
  data_t  model [ELS]; // Reference copy of the RAM.
  int     cyc      = 0;
  int     limit    = 100000; // Replaced once the table is built.
  int     n_checks = 0;
  int     n_errors = 0;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  bit_table_top u_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .cmd_v_i    (cmd_v),
    .cmd_i      (cmd),
    .rsp_v_o    (rsp_v),
    .rsp_data_o (rsp_data),
    .rsp_ones_o (rsp_ones)
  );

  function automatic bit_table_pkg::bit_payload_u wr_payload(data_t data, data_t mask);
    bit_table_pkg::bit_payload_u p;
    p.wr.data = data;
    p.wr.mask = mask;
    return p;
  endfunction

  function automatic bit_table_pkg::bit_payload_u rng_payload(idx_t lo, idx_t hi);
    bit_table_pkg::bit_payload_u p;
    p.rng.lo     = lo;
    p.rng.hi     = hi;
    p.rng.unused = '0;
    return p;
  endfunction

  // Ones from lo upward ANDed with ones from hi downward.
  function automatic data_t range_mask(idx_t lo, idx_t hi);
    data_t all1;
    all1 = '1;
    return (all1 << lo) & (all1 >> (WIDTH - 1 - int'(hi))); // Empty when lo > hi.
  endfunction

  task automatic add_entry(input string name, input bit_table_pkg::bit_op_e op,
                           input addr_t addr, input bit_table_pkg::bit_payload_u payload,
                           input bit check, input int gap);
    entry_t e;
    e.name    = name;
    e.op      = op;
    e.addr    = addr;
    e.payload = payload;
    e.check   = check;
    e.gap     = gap;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    bit_table_pkg::bit_op_e rops[8];
    int rlo[8]   = '{3, 5, 15, 0, 0, 0, 10, 12};
    int rhi[8]   = '{9, 5, 15, 0, 15, 15, 4, 2};
    int raddr[8] = '{30, 30, 30, 30, 31, 31, 32, 33};
    string nm;
    rops = '{bit_table_pkg::OP_SET_RANGE, bit_table_pkg::OP_CLEAR_RANGE,
             bit_table_pkg::OP_SET_RANGE, bit_table_pkg::OP_CLEAR_RANGE,
             bit_table_pkg::OP_SET_RANGE, bit_table_pkg::OP_CLEAR_RANGE,
             bit_table_pkg::OP_SET_RANGE, bit_table_pkg::OP_CLEAR_RANGE};
    // Fill every word, then read all back.
    for (int a = 0; a < ELS; a++) begin
      add_entry($sformatf("fill_%0d", a), bit_table_pkg::OP_WRITE, addr_t'(a),
                wr_payload(data_t'($urandom), '1), 1'b0, 0);
    end
    for (int a = 0; a < ELS; a++) begin
      add_entry($sformatf("fill_rd_%0d", a), bit_table_pkg::OP_READ, addr_t'(a), '0,
                1'b1, (a % 16 == 15) ? 2 : 0);
    end
    // Random data under random masks.
    for (int k = 0; k < 8; k++) begin
      add_entry($sformatf("mask_wr_%0d", 16 + k), bit_table_pkg::OP_WRITE, addr_t'(16 + k),
                wr_payload(data_t'($urandom), data_t'($urandom)), 1'b0, 0);
      add_entry($sformatf("mask_rd_%0d", 16 + k), bit_table_pkg::OP_READ, addr_t'(16 + k),
                '0, 1'b1, k % 2);
    end
    // Ranges, single bits, full word, lo above hi.
    for (int k = 0; k < 8; k++) begin
      nm = $sformatf("%s_%0d_%0d", (rops[k] == bit_table_pkg::OP_SET_RANGE) ? "set" : "clear",
                     rlo[k], rhi[k]);
      add_entry(nm, rops[k], addr_t'(raddr[k]), rng_payload(idx_t'(rlo[k]), idx_t'(rhi[k])),
                1'b0, 0);
      add_entry({nm, "_rd"}, bit_table_pkg::OP_READ, addr_t'(raddr[k]), '0, 1'b1, 0);
    end
    // Write then read next cycle, then a run of reads.
    add_entry("b2b_wr_40", bit_table_pkg::OP_WRITE, addr_t'(40),
              wr_payload(16'hA5C3, '1), 1'b0, 0);
    add_entry("b2b_rd_40", bit_table_pkg::OP_READ, addr_t'(40), '0, 1'b1, 0);
    add_entry("b2b_wr_41", bit_table_pkg::OP_WRITE, addr_t'(41),
              wr_payload(16'h0FF0, 16'h3C3C), 1'b0, 0);
    add_entry("b2b_rd_41", bit_table_pkg::OP_READ, addr_t'(41), '0, 1'b1, 1);
    add_entry("seq_rd_5a", bit_table_pkg::OP_READ, addr_t'(5), '0, 1'b1, 0);
    add_entry("seq_wr_5", bit_table_pkg::OP_WRITE, addr_t'(5),
              wr_payload('1, 16'h8001), 1'b0, 0);
    add_entry("seq_rd_5b", bit_table_pkg::OP_READ, addr_t'(5), '0, 1'b1, 0);
    add_entry("seq_rd_6", bit_table_pkg::OP_READ, addr_t'(6), '0, 1'b1, 0);
    add_entry("seq_rd_7", bit_table_pkg::OP_READ, addr_t'(7), '0, 1'b1, 3);
  endtask

  // Update the model and queue the response of a read.
  task automatic model_command(input entry_t e, input int due);
    data_t wdata;
    data_t wmask;
    resp_t r;
    wdata = '0;
    wmask = '0;
    case (e.op)
      bit_table_pkg::OP_WRITE: begin
        wdata = e.payload.wr.data;
        wmask = e.payload.wr.mask;
      end
      bit_table_pkg::OP_SET_RANGE: begin
        wdata = '1;
        wmask = range_mask(e.payload.rng.lo, e.payload.rng.hi);
      end
      bit_table_pkg::OP_CLEAR_RANGE: begin
        wmask = range_mask(e.payload.rng.lo, e.payload.rng.hi);
      end
      default: begin
        r.name  = e.name;
        r.data  = model[e.addr];
        r.ones  = ones_t'($countones(model[e.addr]));
        r.due   = due;
        r.check = e.check;
        exp_q.push_back(r);
      end
    endcase
    model[e.addr] = (model[e.addr] & ~wmask) | (wdata & wmask);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    n_checks++;
    if (act !== exp) begin
      $display("** Error %s data: expected %h, actual %h", name, exp, act);
      n_errors++;
    end else begin
      $display("ok    %s data %h", name, act);
    end
  endtask

  task automatic check_ones(input string name, input ones_t exp, input ones_t act);
    n_checks++;
    if (act !== exp) begin
      $display("** Error %s ones: expected %0d, actual %0d", name, exp, act);
      n_errors++;
    end else begin
      $display("ok    %s ones %0d", name, act);
    end
  endtask

  // Cycle count and run limit.
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("Timeout at cycle %0d with %0d responses pending", cyc, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  // Responses sampled mid-cycle, away from the edge.
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      // Strobe is cleared from the first edge on.
      if (cyc > 0 && rsp_v !== 1'b0) begin
        $display("rsp_v_o is not low during reset at cycle %0d", cyc);
        n_errors++;
      end
    end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      if (rsp_v !== 1'b1) begin
        $display("Missing rsp_v_o pulse for %s at cycle %0d", exp_q[0].name, cyc);
        n_errors++;
      end else if (exp_q[0].check) begin
        check_data(exp_q[0].name, exp_q[0].data, rsp_data);
        check_ones(exp_q[0].name, exp_q[0].ones, rsp_ones);
      end
      void'(exp_q.pop_front());
    end else if (rsp_v !== 1'b0) begin
      $display("Extra rsp_v_o pulse at cycle %0d with no read pending", cyc);
      n_errors++;
    end
  end

  initial begin
    cmd_v = 1'b0;
    cmd   = '0;
    void'($urandom(SEED));
    build_table();
    limit = tbl.size() * 4 + 20;
    wait (rst_n === 1'b1);
    foreach (tbl[i]) begin
      @(posedge clk);
      cmd_v      <= 1'b1;
      cmd.op      <= tbl[i].op;
      cmd.addr    <= tbl[i].addr;
      cmd.payload <= tbl[i].payload;
      model_command(tbl[i], cyc + 4); // Sampled next edge, three more to rsp_v_o.
      repeat (tbl[i].gap) begin
        @(posedge clk);
        cmd_v <= 1'b0;
      end
    end
    @(posedge clk);
    cmd_v <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (6) @(posedge clk); // Catch any late extra pulse.
    $display("Summary: %0d commands, %0d checks, %0d errors", tbl.size(), n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Testbench clock and reset, 4 ns period, reset low for 5 cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // Half of 4 ns.
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1; // Released on the fifth edge.
  end

endmodule

`default_nettype wire

// File: source/bit_table_top.sv
// Bit-state table top level.
// Decode, masked-write RAM and read result in a three-cycle pipe.
`timescale 1ns/1ps
`default_nettype none

module bit_table_top #(
  parameter int WIDTH  = bit_table_pkg::WIDTH,
  parameter int ELS    = bit_table_pkg::ELS,
  parameter int ADDR_W = bit_table_pkg::ADDR_W,
  parameter int CNT_W  = bit_table_pkg::CNT_W
) (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     cmd_v_i,    // One-cycle command strobe.
  input  bit_table_pkg::bit_cmd_t cmd_i,
  output logic                    rsp_v_o,    // Three cycles after a read.
  output logic [WIDTH-1:0]        rsp_data_o,
  output logic [CNT_W-1:0]        rsp_ones_o
);

  logic             rd_v;
  logic [WIDTH-1:0] rd_data;

  // Decode to RAM request.
  bit_wr_if #(
    .WIDTH  (WIDTH),
    .ADDR_W (ADDR_W)
  ) u_wr ();

  bit_cmd_decode #(
    .WIDTH  (WIDTH),
    .ADDR_W (ADDR_W)
  ) u_decode (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cmd_v_i (cmd_v_i),
    .cmd_i   (cmd_i),
    .wr      (u_wr.master)
  );

  // Execute stage.
  mem_1rw_sync_mask_write_bit #(
    .WIDTH (WIDTH),
    .ELS   (ELS)
  ) u_mem (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr        (u_wr.slave),
    .rd_v_o    (rd_v),
    .rd_data_o (rd_data)
  );

  bit_read_result #(
    .WIDTH (WIDTH),
    .CNT_W (CNT_W)
  ) u_result (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd_v_i     (rd_v),
    .rd_data_i  (rd_data),
    .rsp_v_o    (rsp_v_o),
    .rsp_data_o (rsp_data_o),
    .rsp_ones_o (rsp_ones_o)
  );

endmodule

`default_nettype wire

// File: source/bit_read_result.sv
// Read result stage.
// Registers the read word together with its count of set bits.
`timescale 1ns/1ps
`default_nettype none

module bit_read_result #(
  parameter int WIDTH = 16,
  parameter int CNT_W = 5
) (
  input  wire              clk_i,
  input  wire              rst_n_i,
  input  wire              rd_v_i,
  input  wire [WIDTH-1:0]  rd_data_i,
  output logic             rsp_v_o,
  output logic [WIDTH-1:0] rsp_data_o,
  output logic [CNT_W-1:0] rsp_ones_o
);

  logic [CNT_W-1:0] ones_d;
  logic [WIDTH-1:0] data_q;
  logic [CNT_W-1:0] ones_q;

  // Population count, plain adder chain.
  always_comb begin
    ones_d = '0;
    for (int i = 0; i < WIDTH; i++) begin
      ones_d = ones_d + CNT_W'(rd_data_i[i]);
    end
  end

  // Response strobe.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_v_o <= 1'b0;
    end else begin
      rsp_v_o <= rd_v_i; // One cycle per read.
    end
  end

  // Word and count captured only on a read.
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      data_q <= rd_data_i;
      ones_q <= ones_d;
    end
  end

  assign rsp_data_o = data_q;
  assign rsp_ones_o = ones_q;

endmodule

`default_nettype wire

// File: source/mem_1rw_sync_mask_write_bit.sv
// Single-port synchronous RAM, per-bit write mask.
// Registered read in no-change mode, data holds until the next read.
`timescale 1ns/1ps
`default_nettype none

module mem_1rw_sync_mask_write_bit #(
  parameter int WIDTH = 16,
  parameter int ELS   = 64
) (
  input  wire              clk_i,
  input  wire              rst_n_i,
  bit_wr_if.slave          wr,
  output logic             rd_v_o,
  output logic [WIDTH-1:0] rd_data_o
);

  localparam int ADDR_W = $clog2(ELS);

  logic [WIDTH-1:0]  mem [ELS]; // No reset, written before read.
  logic [ADDR_W-1:0] addr;
  logic [WIDTH-1:0]  data_r;

  assign addr = wr.addr;

  // Only masked bits change.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < WIDTH; i++) begin
      if (wr.v && wr.we && wr.mask[i]) begin
        mem[addr][i] <= wr.data[i];
      end
    end
  end

  // Read word, held between reads.
  always_ff @(posedge clk_i) begin
    if (wr.v && !wr.we) begin
      data_r <= mem[addr];
    end
  end

  // Valid pulse for each read.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_v_o <= 1'b0;
    end else begin
      rd_v_o <= wr.v && !wr.we;
    end
  end

  assign rd_data_o = data_r;

endmodule

`default_nettype wire

// File: source/bit_cmd_decode.sv
// Command decode stage.
// Registers each command as a masked write or a read request.
`timescale 1ns/1ps
`default_nettype none

module bit_cmd_decode #(
  parameter int WIDTH  = 16,
  parameter int ADDR_W = 6
) (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     cmd_v_i,
  input  bit_table_pkg::bit_cmd_t cmd_i,
  bit_wr_if.master                wr
);

  logic              we_d;
  logic [ADDR_W-1:0] addr_d;
  logic [WIDTH-1:0]  data_d;
  logic [WIDTH-1:0]  mask_d;
  logic [WIDTH-1:0]  rng_mask;

  logic              v_q;
  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [WIDTH-1:0]  data_q;
  logic [WIDTH-1:0]  mask_q;

  // Range mask, 1 from lo to hi inclusive.
  // lo above hi leaves it all zero.
  always_comb begin
    for (int i = 0; i < WIDTH; i++) begin
      rng_mask[i] = (i >= int'(cmd_i.payload.rng.lo)) &&
                    (i <= int'(cmd_i.payload.rng.hi));
    end
  end

  assign addr_d = cmd_i.addr;

  // Opcode picks the payload view.
  always_comb begin
    we_d   = 1'b1;
    data_d = '0;
    mask_d = '0;
    case (cmd_i.op)
      bit_table_pkg::OP_WRITE: begin
        data_d = cmd_i.payload.wr.data; // Pass through.
        mask_d = cmd_i.payload.wr.mask;
      end
      bit_table_pkg::OP_SET_RANGE: begin
        data_d = '1;        // Ones under the mask.
        mask_d = rng_mask;
      end
      bit_table_pkg::OP_CLEAR_RANGE: begin
        data_d = '0;        // Zeros under the mask.
        mask_d = rng_mask;
      end
      default: we_d = 1'b0; // OP_READ.
    endcase
  end

  // Strobe is the only control bit.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_q <= 1'b0;
    end else begin
      v_q <= cmd_v_i;
    end
  end

  // Request fields load with each command.
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      we_q   <= we_d;
      addr_q <= addr_d;
      data_q <= data_d;
      mask_q <= mask_d;
    end
  end

  assign wr.v    = v_q;
  assign wr.we   = we_q;
  assign wr.addr = addr_q;
  assign wr.data = data_q;
  assign wr.mask = mask_q;

endmodule

`default_nettype wire

// File: source/bit_wr_if.sv
// Decoded RAM request between decode and the masked-write RAM.
`timescale 1ns/1ps
`default_nettype none

interface bit_wr_if #(
  parameter int WIDTH  = 16,
  parameter int ADDR_W = 6
) ();

  logic              v;     // One-cycle request strobe.
  logic              we;    // 1 = masked write, 0 = read.
  logic [ADDR_W-1:0] addr;  // Word address.
  logic [WIDTH-1:0]  data;  // Write data.
  logic [WIDTH-1:0]  mask;  // Per-bit write enable.

  // Request source.
  modport master (
    output v,
    output we,
    output addr,
    output data,
    output mask
  );

  // Request sink, the RAM.
  modport slave (
    input v,
    input we,
    input addr,
    input data,
    input mask
  );

endinterface

`default_nettype wire

// File: source/bit_table_pkg.sv
// Bit-state table shared definitions.
// Widths, opcodes and the command word with its two payload views.
`default_nettype none

package bit_table_pkg;

  localparam int WIDTH  = 16;              // Bits per word.
  localparam int ELS    = 64;              // Words in the table.
  localparam int ADDR_W = $clog2(ELS);     // Word address width.
  localparam int CNT_W  = $clog2(WIDTH) + 1; // Holds 0..WIDTH.
  localparam int IDX_W  = $clog2(WIDTH);   // Bit index inside a word.
  localparam int PLD_W  = 2 * WIDTH;       // Payload width.

  // Command opcodes.
  typedef enum logic [1:0] {
    OP_READ        = 2'd0,
    OP_WRITE       = 2'd1,
    OP_SET_RANGE   = 2'd2,
    OP_CLEAR_RANGE = 2'd3
  } bit_op_e;

  // Explicit masked write.
  typedef struct packed {
    logic [WIDTH-1:0] data;  // New bit values.
    logic [WIDTH-1:0] mask;  // 1 = bit is written.
  } bit_wr_s;

  // Contiguous range, lo..hi inclusive.
  typedef struct packed {
    logic [IDX_W-1:0]         lo;
    logic [IDX_W-1:0]         hi;
    logic [PLD_W-2*IDX_W-1:0] unused;  // Ignored by decode.
  } bit_rng_s;

  // Same payload bits, read by opcode.
  typedef union packed {
    bit_wr_s  wr;
    bit_rng_s rng;
  } bit_payload_u;

  // 40-bit command word.
  typedef struct packed {
    bit_op_e             op;
    logic [ADDR_W-1:0]   addr;
    bit_payload_u        payload;
  } bit_cmd_t;

endpackage

`default_nettype wire
